//--- verilog.f
hw/emesh_rx_pkg.sv
hw/rx_distributor.sv
hw/rx_queue.sv
hw/rx_flow_ctrl.sv
hw/emesh_rx.sv
testbench/emesh_rx_properties.sv
testbench/emesh_rx_tb.sv

//--- Makefile
# Verilator build and run for the eMesh receive testbench

SIM_TOOL  ?= verilator
SIM_FLAGS ?= --binary --timing --assert -j 0
TOP       ?= emesh_rx_tb
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  := ALL CHECKS PASSED

.PHONY: all compile run clean

all: run

compile:
	$(SIM_TOOL) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- testbench/emesh_rx_tb.sv
// Testbench emesh_rx_tb: clock, reset, random traffic, credit consumers, reference model, checks

`timescale 1ns/1ps

module emesh_rx_tb
  import emesh_rx_pkg::*;
();

  localparam int clk_period  = 8;
  // Routing 60, credits 24, back-pressure 20, enable 10
  localparam int total_txns  = 114;
  localparam int cycle_bound = 40;
  localparam int watchdog_ns = (total_txns * cycle_bound + 16) * clk_period;

  logic                  clk = 1'b0;
  logic                  rst;
  logic                  rx_enable;
  logic                  emesh_access;
  logic                  emesh_write;
  logic [datamode_w-1:0] emesh_datamode;
  logic [ctrlmode_w-1:0] emesh_ctrlmode;
  logic [addr_w-1:0]     emesh_dstaddr;
  logic [addr_w-1:0]     emesh_srcaddr;
  logic [data_w-1:0]     emesh_data;
  wire                   emesh_rd_wait;
  wire                   emesh_wr_wait;
  wire  [num_ch-1:0]     out_valid;
  wire  [txn_w-1:0]      out_data [num_ch];
  logic [num_ch-1:0]     credit_ret = '0;
  logic [num_ch-1:0]     release_en;

  // Expected words, tail moved by the sender, head by the compare
  logic [txn_w-1:0] exp_mem [num_ch][256];
  int exp_tail [num_ch];
  int exp_head [num_ch];
  int delivered [num_ch];
  int returned [num_ch];
  int base [num_ch];
  int checks;
  int errors;
  int cmp_checks;
  int cmp_errors;
  int mark;
  integer seed;

  always #(clk_period / 2) clk = ~clk;

  emesh_rx dut_i (
    .clk (clk), .rst (rst), .rx_enable (rx_enable),
    .emesh_access (emesh_access), .emesh_write (emesh_write),
    .emesh_datamode (emesh_datamode), .emesh_ctrlmode (emesh_ctrlmode),
    .emesh_dstaddr (emesh_dstaddr), .emesh_srcaddr (emesh_srcaddr), .emesh_data (emesh_data),
    .emesh_rd_wait (emesh_rd_wait), .emesh_wr_wait (emesh_wr_wait),
    .wr_out_valid (out_valid[ch_wr]), .wr_out_data (out_data[ch_wr]),
    .wr_credit_return (credit_ret[ch_wr]),
    .rq_out_valid (out_valid[ch_rq]), .rq_out_data (out_data[ch_rq]),
    .rq_credit_return (credit_ret[ch_rq]),
    .rr_out_valid (out_valid[ch_rr]), .rr_out_data (out_data[ch_rr]),
    .rr_credit_return (credit_ret[ch_rr])
  );

  // ############################################################
  // Reference model and helpers
  // ############################################################

  function automatic string ch_name(input int c);
    begin
      ch_name = (c == ch_wr) ? "wr" : ((c == ch_rq) ? "rq" : "rr");
    end
  endfunction

  // Reads go to rq, tagged writes to rr, all other writes to wr
  function automatic int expected_channel(input logic [txn_w-1:0] w);
    emesh_dstaddr_u dst;
    begin
      dst.flat = w[addr_w+data_w +: addr_w];
      if (!w[txn_w-1])
        expected_channel = ch_rq;
      else if (dst.route.tag == read_tag_addr)
        expected_channel = ch_rr;
      else
        expected_channel = ch_wr;
    end
  endfunction

  // Random word of the requested kind, address built via the tag view
  function automatic logic [txn_w-1:0] make_txn(input int kind);
    emesh_dstaddr_u dst;
    logic [31:0] r0;
    logic [31:0] r1;
    logic [31:0] r2;
    logic [31:0] r3;
    begin
      r0 = $random(seed);
      r1 = $random(seed);
      r2 = $random(seed);
      r3 = $random(seed);
      dst.flat = r0;
      if (kind == ch_rr)
        dst.route.tag = read_tag_addr;
      else if (kind == ch_wr && dst.route.tag == read_tag_addr)
        dst.route.tag = ~read_tag_addr;
      make_txn = {(kind != ch_rq), r1[1:0], r1[5:2], dst.flat, r2, r3};
    end
  endfunction

  function automatic int total_errors();
    begin
      total_errors = errors + cmp_errors;
    end
  endfunction

  // Everything sent came out and every credit went back
  function automatic logic all_done();
    begin
      all_done = 1'b1;
      for (int c = 0; c < num_ch; c++)
      begin
        if (exp_head[c] != exp_tail[c] || returned[c] != delivered[c])
          all_done = 1'b0;
      end
    end
  endfunction

  // Honors the matching wait, then drives one access
  task automatic issue(input logic [txn_w-1:0] w, input logic expect_out);
    logic stall;
    int   c;
    begin
      stall = 1'b1;
      while (stall)
      begin
        @(negedge clk);
        stall = w[txn_w-1] ? emesh_wr_wait : emesh_rd_wait;
        if (stall)
        begin
          @(posedge clk);
          emesh_access <= 1'b0;
        end
      end
      @(posedge clk);
      emesh_access <= 1'b1;
      {emesh_write, emesh_datamode, emesh_ctrlmode, emesh_dstaddr, emesh_srcaddr, emesh_data} <= w;
      if (expect_out)
      begin
        c = expected_channel(w);
        exp_mem[c][exp_tail[c]] = w;
        exp_tail[c] = exp_tail[c] + 1;
      end
    end
  endtask

  task automatic drain();
    begin
      @(posedge clk);
      emesh_access <= 1'b0;
      while (!all_done())
        @(negedge clk);
    end
  endtask

  task automatic take_base();
    begin
      for (int c = 0; c < num_ch; c++)
        base[c] = delivered[c];
    end
  endtask

  task automatic check_delivered(input int extra, input string what);
    begin
      for (int c = 0; c < num_ch; c++)
      begin
        checks++;
        if (delivered[c] != base[c] + extra)
        begin
          $display("Channel %s gave %0d words %s, wanted %0d", ch_name(c),
                   delivered[c] - base[c], what, extra);
          errors++;
        end
      end
    end
  endtask

  task automatic report_test(input string name);
    begin
      if (total_errors() == mark)
        $display("Test %s: ok", name);
      else
        $display("Test %s: failed with %0d errors", name, total_errors() - mark);
      mark = total_errors();
    end
  endtask

  // ############################################################
  // Consumers and compare
  // ############################################################

  // One credit back per cycle for every word taken, while released
  always @(posedge clk)
  begin
    for (int c = 0; c < num_ch; c++)
    begin
      if (release_en[c] && returned[c] != delivered[c])
      begin
        credit_ret[c] <= 1'b1;
        returned[c]   <= returned[c] + 1;
      end
      else
      begin
        credit_ret[c] <= 1'b0;
      end
    end
  end

  always @(negedge clk)
  begin
    if (!rst)
    begin
      for (int c = 0; c < num_ch; c++)
      begin
        if (out_valid[c])
        begin
          delivered[c] = delivered[c] + 1;
          cmp_checks++;
          if (exp_head[c] == exp_tail[c])
          begin
            $display("Channel %s delivered a word nobody sent to it", ch_name(c));
            cmp_errors++;
          end
          else
          begin
            if (out_data[c] !== exp_mem[c][exp_head[c]])
            begin
              $display("** Error %s_out_data: expected %h, got %h", ch_name(c),
                       exp_mem[c][exp_head[c]], out_data[c]);
              cmp_errors++;
            end
            exp_head[c] = exp_head[c] + 1;
          end
        end
      end
    end
  end

  initial
  begin
    #(watchdog_ns);
    $display("Watchdog expired after %0d ns with traffic still pending", watchdog_ns);
    $display("CHECKS FAILED");
    $finish;
  end

  // ############################################################
  // Test sequence
  // ############################################################

  initial
  begin
    logic [31:0] r;
    logic        wait_seen;
    seed           = 92;
    rst            = 1'b1;
    rx_enable      = 1'b1;
    emesh_access   = 1'b0;
    emesh_write    = 1'b0;
    emesh_datamode = '0;
    emesh_ctrlmode = '0;
    emesh_dstaddr  = '0;
    emesh_srcaddr  = '0;
    emesh_data     = '0;
    release_en     = '1;
    repeat (16) @(posedge clk);
    rst <= 1'b0;

    // Idle after reset
    repeat (4) @(negedge clk);
    checks += 2;
    if (out_valid !== '0)
    begin
      $display("** Error out_valid: expected 0, got %h", out_valid);
      errors++;
    end
    if ({emesh_rd_wait, emesh_wr_wait} !== 2'b00)
    begin
      $display("** Error emesh_rd_wait/emesh_wr_wait: expected 0, got %h",
               {emesh_rd_wait, emesh_wr_wait});
      errors++;
    end
    report_test("reset");

    // Random mix, each word on its channel and in order
    for (int i = 0; i < 60; i++)
    begin
      r = $random(seed);
      issue(make_txn(r % num_ch), 1'b1);
    end
    drain();
    report_test("routing and order");

    // Withheld credits cap each channel at credit_init
    take_base();
    release_en = '0;
    for (int i = 0; i < 24; i++)
      issue(make_txn(i % num_ch), 1'b1);
    drain_access: begin
      @(posedge clk);
      emesh_access <= 1'b0;
    end
    for (int c = 0; c < num_ch; c++)
    begin
      while (delivered[c] < base[c] + int'(credit_init))
        @(negedge clk);
    end
    repeat (20) @(negedge clk);
    check_delivered(int'(credit_init), "with credits withheld");
    // Two returned credits per channel release two more words
    release_en = '1;
    repeat (2) @(negedge clk);
    release_en = '0;
    repeat (20) @(negedge clk);
    check_delivered(int'(credit_init) + 2, "after two credits returned");
    release_en = '1;
    drain();
    check_delivered(8, "after credits resumed");
    report_test("credits");

    // Queue fills, wait stops the sender, release lets it finish
    release_en = '0;
    wait_seen  = 1'b0;
    fork
      begin
        for (int i = 0; i < 20; i++)
          issue(make_txn(ch_wr), 1'b1);
      end
      begin
        for (int n = 0; n < 60 && !emesh_wr_wait; n++)
          @(negedge clk);
        wait_seen = emesh_wr_wait;
        repeat (8) @(negedge clk);
        release_en = '1;
      end
    join
    drain();
    checks++;
    if (!wait_seen)
    begin
      $display("Write wait never rose while the write queue filled");
      errors++;
    end
    report_test("back-pressure");

    // Accesses with the link disabled are dropped
    take_base();
    @(posedge clk);
    rx_enable <= 1'b0;
    for (int i = 0; i < 10; i++)
      issue(make_txn(i % num_ch), 1'b0);
    @(posedge clk);
    emesh_access <= 1'b0;
    @(posedge clk);
    rx_enable <= 1'b1;
    repeat (20) @(negedge clk);
    check_delivered(0, "while disabled");
    report_test("enable");

    $display("Summary: %0d checks, %0d errors", checks + cmp_checks, total_errors());
    if (total_errors() == 0)
      $display("ALL CHECKS PASSED");
    else
      $display("CHECKS FAILED");
    $finish;
  end

endmodule

//--- testbench/emesh_rx_properties.sv
// Module emesh_rx_properties: bound checks on push one-hot, credit limits, overflow and waits

`timescale 1ns/1ps

module emesh_rx_properties
  import emesh_rx_pkg::*;
(
  input logic                     clk,
  input logic                     rst,
  input logic                     wr_push,
  input logic                     rq_push,
  input logic                     rr_push,
  input logic                     wr_pop,
  input logic                     rq_pop,
  input logic                     rr_pop,
  input logic [queue_level_w-1:0] wr_level,
  input logic [queue_level_w-1:0] rq_level,
  input logic [queue_level_w-1:0] rr_level,
  input logic                     wr_prog_full,
  input logic                     rq_prog_full,
  input logic                     rr_prog_full,
  input logic                     wr_credit_return,
  input logic                     rq_credit_return,
  input logic                     rr_credit_return
);

  localparam logic [queue_level_w-1:0] full_level = queue_level_w'(queue_depth);

  logic [num_ch-1:0]   pop_v;
  logic [num_ch-1:0]   ret_v;
  // Words handed to a consumer and not yet returned
  logic [credit_w-1:0] owed [num_ch];

  assign pop_v = {rr_pop, rq_pop, wr_pop};
  assign ret_v = {rr_credit_return, rq_credit_return, wr_credit_return};

  always_ff @(posedge clk)
  begin
    for (int i = 0; i < num_ch; i++)
    begin
      if (rst)
      begin
        owed[i] <= '0;
      end
      else
      begin
        case ({pop_v[i], ret_v[i]})
          2'b10:   owed[i] <= owed[i] + 1'b1;
          2'b01:   owed[i] <= owed[i] - 1'b1;
          default: owed[i] <= owed[i];
        endcase
      end
    end
  end

  // ############################################################
  // Assertions
  // ############################################################

  // Shared word goes to one queue at most
  push_onehot_a: assert property (@(posedge clk) disable iff (rst)
    $onehot0({wr_push, rq_push, rr_push}))
    else $error("More than one channel push in one cycle");

  credit_limit_a: assert property (@(posedge clk) disable iff (rst)
    (owed[ch_wr] <= credit_init) && (owed[ch_rq] <= credit_init) && (owed[ch_rr] <= credit_init))
    else $error("Consumer holds more words than its credits");

  // Push into a full queue only with a pop alongside
  no_overflow_a: assert property (@(posedge clk) disable iff (rst)
    (!wr_push || wr_pop || (wr_level != full_level)) &&
    (!rq_push || rq_pop || (rq_level != full_level)) &&
    (!rr_push || rr_pop || (rr_level != full_level)))
    else $error("Queue written while full");

  // Sender stops the cycle after it sees wait
  // Two cycles of prog-full leave no push still in flight
  wait_obeyed_a: assert property (@(posedge clk) disable iff (rst)
    !(wr_push && $past(wr_prog_full) && $past(wr_prog_full, 2)) &&
    !(rq_push && $past(rq_prog_full) && $past(rq_prog_full, 2)) &&
    !(rr_push && $past(rr_prog_full) && $past(rr_prog_full, 2)))
    else $error("Queue pushed after its wait had stopped the sender");

endmodule

bind emesh_rx emesh_rx_properties props_i (
  .clk (clk), .rst (rst),
  .wr_push (wr_push), .rq_push (rq_push), .rr_push (rr_push),
  .wr_pop (wr_pop), .rq_pop (rq_pop), .rr_pop (rr_pop),
  .wr_level (wr_level), .rq_level (rq_level), .rr_level (rr_level),
  .wr_prog_full (wr_prog_full), .rq_prog_full (rq_prog_full), .rr_prog_full (rr_prog_full),
  .wr_credit_return (wr_credit_return), .rq_credit_return (rq_credit_return),
  .rr_credit_return (rr_credit_return)
);

//--- hw/emesh_rx.sv
// Module emesh_rx: receive top with distributor, three channel queues and flow controller

`timescale 1ns/1ps

module emesh_rx
  import emesh_rx_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  rx_enable,
  // eMesh input
  input  logic                  emesh_access,
  input  logic                  emesh_write,
  input  logic [datamode_w-1:0] emesh_datamode,
  input  logic [ctrlmode_w-1:0] emesh_ctrlmode,
  input  logic [addr_w-1:0]     emesh_dstaddr,
  input  logic [addr_w-1:0]     emesh_srcaddr,
  input  logic [data_w-1:0]     emesh_data,
  output logic                  emesh_rd_wait,
  output logic                  emesh_wr_wait,
  // Write channel
  output logic                  wr_out_valid,
  output logic [txn_w-1:0]      wr_out_data,
  input  logic                  wr_credit_return,
  // Read request channel
  output logic                  rq_out_valid,
  output logic [txn_w-1:0]      rq_out_data,
  input  logic                  rq_credit_return,
  // Read response channel
  output logic                  rr_out_valid,
  output logic [txn_w-1:0]      rr_out_data,
  input  logic                  rr_credit_return
);

  // ############################################################
  // Internal nets
  // ############################################################

  logic [txn_w-1:0] txn_word;
  logic wr_push, rq_push, rr_push;
  logic wr_pop, rq_pop, rr_pop;
  logic wr_empty, rq_empty, rr_empty;
  logic [queue_level_w-1:0] wr_level, rq_level, rr_level;
  // Prog-full flags feed the bound checks only
  logic wr_prog_full, rq_prog_full, rr_prog_full;

  rx_distributor distributor_i (
    .clk            (clk),
    .rst            (rst),
    .rx_enable      (rx_enable),
    .emesh_access   (emesh_access),
    .emesh_write    (emesh_write),
    .emesh_datamode (emesh_datamode),
    .emesh_ctrlmode (emesh_ctrlmode),
    .emesh_dstaddr  (emesh_dstaddr),
    .emesh_srcaddr  (emesh_srcaddr),
    .emesh_data     (emesh_data),
    .txn_word       (txn_word),
    .wr_push        (wr_push),
    .rq_push        (rq_push),
    .rr_push        (rr_push)
  );

  // One queue per channel, all fed from the shared word
  rx_queue wr_queue_i (
    .clk (clk), .rst (rst), .push (wr_push), .push_data (txn_word), .pop (wr_pop),
    .pop_data (wr_out_data), .empty (wr_empty), .level (wr_level), .prog_full (wr_prog_full)
  );

  rx_queue rq_queue_i (
    .clk (clk), .rst (rst), .push (rq_push), .push_data (txn_word), .pop (rq_pop),
    .pop_data (rq_out_data), .empty (rq_empty), .level (rq_level), .prog_full (rq_prog_full)
  );

  rx_queue rr_queue_i (
    .clk (clk), .rst (rst), .push (rr_push), .push_data (txn_word), .pop (rr_pop),
    .pop_data (rr_out_data), .empty (rr_empty), .level (rr_level), .prog_full (rr_prog_full)
  );

  rx_flow_ctrl flow_ctrl_i (
    .clk              (clk),
    .rst              (rst),
    .wr_empty         (wr_empty),
    .rq_empty         (rq_empty),
    .rr_empty         (rr_empty),
    .wr_level         (wr_level),
    .rq_level         (rq_level),
    .rr_level         (rr_level),
    .wr_pop           (wr_pop),
    .rq_pop           (rq_pop),
    .rr_pop           (rr_pop),
    .wr_credit_return (wr_credit_return),
    .rq_credit_return (rq_credit_return),
    .rr_credit_return (rr_credit_return),
    .wr_out_valid     (wr_out_valid),
    .rq_out_valid     (rq_out_valid),
    .rr_out_valid     (rr_out_valid),
    .emesh_rd_wait    (emesh_rd_wait),
    .emesh_wr_wait    (emesh_wr_wait)
  );

endmodule

//--- hw/rx_flow_ctrl.sv
// Module rx_flow_ctrl: per-channel credit counters, queue pops, output valids and sender waits

`timescale 1ns/1ps

module rx_flow_ctrl
  import emesh_rx_pkg::*;
(
  input  logic                     clk,
  input  logic                     rst,
  // Queue status
  input  logic                     wr_empty,
  input  logic                     rq_empty,
  input  logic                     rr_empty,
  input  logic [queue_level_w-1:0] wr_level,
  input  logic [queue_level_w-1:0] rq_level,
  input  logic [queue_level_w-1:0] rr_level,
  // Queue pops
  output logic                     wr_pop,
  output logic                     rq_pop,
  output logic                     rr_pop,
  // Consumer side
  input  logic                     wr_credit_return,
  input  logic                     rq_credit_return,
  input  logic                     rr_credit_return,
  output logic                     wr_out_valid,
  output logic                     rq_out_valid,
  output logic                     rr_out_valid,
  // Toward the sender
  output logic                     emesh_rd_wait,
  output logic                     emesh_wr_wait
);

  // ############################################################
  // Channel vectors
  // ############################################################

  logic [num_ch-1:0]   empty_v;
  logic [num_ch-1:0]   ret_v;
  logic [num_ch-1:0]   pop_v;
  logic [num_ch-1:0]   valid_q;
  logic [credit_w-1:0] credit_q [num_ch];

  assign empty_v[ch_wr] = wr_empty;
  assign empty_v[ch_rq] = rq_empty;
  assign empty_v[ch_rr] = rr_empty;

  assign ret_v[ch_wr] = wr_credit_return;
  assign ret_v[ch_rq] = rq_credit_return;
  assign ret_v[ch_rr] = rr_credit_return;

  // Pop whenever a credit and a word are both there
  always_comb
  begin
    for (int i = 0; i < num_ch; i++)
    begin
      pop_v[i] = (credit_q[i] != '0) & ~empty_v[i];
    end
  end

  // ############################################################
  // Credit counters and output valid
  // ############################################################

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      valid_q <= '0;
      for (int i = 0; i < num_ch; i++)
      begin
        credit_q[i] <= credit_init;
      end
    end
    else
    begin
      // Valid lines up with the registered queue read port
      valid_q <= pop_v;
      for (int i = 0; i < num_ch; i++)
      begin
        // Return plus pop in one cycle cancels out
        case ({ret_v[i], pop_v[i]})
          2'b10:   credit_q[i] <= credit_q[i] + 1'b1;
          2'b01:   credit_q[i] <= credit_q[i] - 1'b1;
          default: credit_q[i] <= credit_q[i];
        endcase
      end
    end
  end

  assign wr_pop = pop_v[ch_wr];
  assign rq_pop = pop_v[ch_rq];
  assign rr_pop = pop_v[ch_rr];

  assign wr_out_valid = valid_q[ch_wr];
  assign rq_out_valid = valid_q[ch_rq];
  assign rr_out_valid = valid_q[ch_rr];

  // Waits straight from the levels, same split as the sender's two kinds
  assign emesh_rd_wait = (rq_level >= prog_full_level);
  assign emesh_wr_wait = (wr_level >= prog_full_level) | (rr_level >= prog_full_level);

endmodule

//--- hw/rx_queue.sv
// Module rx_queue: synchronous FIFO with registered read port, level count and prog-full flag

`timescale 1ns/1ps

module rx_queue
  import emesh_rx_pkg::*;
(
  input  logic                     clk,
  input  logic                     rst,
  // Write side, from the distributor
  input  logic                     push,
  input  logic [txn_w-1:0]         push_data,
  // Read side, from the flow controller
  input  logic                     pop,
  output logic [txn_w-1:0]         pop_data,
  // Status
  output logic                     empty,
  output logic [queue_level_w-1:0] level,
  output logic                     prog_full
);

  // ############################################################
  // Storage and pointers
  // ############################################################

  logic [txn_w-1:0]       mem [queue_depth];
  logic [queue_ptr_w-1:0] wr_ptr;
  logic [queue_ptr_w-1:0] rd_ptr;

  // Pointers wrap on their own, depth is a power of two
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end
    else
    begin
      if (push)
      begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop)
      begin
        rd_ptr <= rd_ptr + 1'b1;
      end
    end
  end

  // Write port
  always_ff @(posedge clk)
  begin
    if (push)
    begin
      mem[wr_ptr] <= push_data;
    end
  end

  // Registered read port, holds its word between pops
  always_ff @(posedge clk)
  begin
    if (pop)
    begin
      pop_data <= mem[rd_ptr];
    end
  end

  // ############################################################
  // Fill level
  // ############################################################

  // Push and pop together leave the level as it is
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      level <= '0;
    end
    else
    begin
      case ({push, pop})
        2'b10:   level <= level + 1'b1;
        2'b01:   level <= level - 1'b1;
        default: level <= level;
      endcase
    end
  end

  assign empty     = (level == '0);
  // Raised early enough for the in-flight margin
  assign prog_full = (level >= prog_full_level);

endmodule

//--- hw/rx_distributor.sv
// Module rx_distributor: input register stage and write/read-request/read-response sort

`timescale 1ns/1ps

module rx_distributor
  import emesh_rx_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  rx_enable,
  // Raw eMesh transaction from the sender
  input  logic                  emesh_access,
  input  logic                  emesh_write,
  input  logic [datamode_w-1:0] emesh_datamode,
  input  logic [ctrlmode_w-1:0] emesh_ctrlmode,
  input  logic [addr_w-1:0]     emesh_dstaddr,
  input  logic [addr_w-1:0]     emesh_srcaddr,
  input  logic [data_w-1:0]     emesh_data,
  // Shared word plus one push per channel queue
  output logic [txn_w-1:0]      txn_word,
  output logic                  wr_push,
  output logic                  rq_push,
  output logic                  rr_push
);

  // ############################################################
  // Input register stage
  // ############################################################

  logic                  in_write;
  logic [datamode_w-1:0] in_datamode;
  logic [ctrlmode_w-1:0] in_ctrlmode;
  logic [addr_w-1:0]     in_dstaddr;
  logic [addr_w-1:0]     in_srcaddr;
  logic [data_w-1:0]     in_data;

  // Tag view of the incoming destination
  emesh_dstaddr_u dst_view;
  logic           accept;
  logic           tag_hit;

  assign dst_view = emesh_dstaddr;
  assign tag_hit  = (dst_view.route.tag == read_tag_addr);
  // Accesses are dropped while the link is disabled
  assign accept   = emesh_access & rx_enable;

  // Payload, sampled every cycle
  always_ff @(posedge clk)
  begin
    in_write    <= emesh_write;
    in_datamode <= emesh_datamode;
    in_ctrlmode <= emesh_ctrlmode;
    in_dstaddr  <= emesh_dstaddr;
    in_srcaddr  <= emesh_srcaddr;
    in_data     <= emesh_data;
  end

  // ############################################################
  // Channel select
  // ############################################################

  // One push at most, cleared on idle cycles
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      wr_push <= 1'b0;
      rq_push <= 1'b0;
      rr_push <= 1'b0;
    end
    else
    begin
      rq_push <= accept & ~emesh_write;
      rr_push <= accept & emesh_write & tag_hit;
      wr_push <= accept & emesh_write & ~tag_hit;
    end
  end

  // Same field order as the sender side
  assign txn_word = {in_write, in_datamode, in_ctrlmode, in_dstaddr, in_srcaddr, in_data};

endmodule

//--- hw/emesh_rx_pkg.sv
// Package: eMesh transaction widths, read tag, queue and credit constants, dstaddr union

package emesh_rx_pkg;

  // ############################################################
  // Transaction field widths
  // ############################################################

  // Single-bit write flag sits at the top of the word
  localparam int datamode_w = 2;
  localparam int ctrlmode_w = 4;
  localparam int addr_w     = 32;
  localparam int data_w     = 32;

  // Packed word: write, datamode, ctrlmode, dstaddr, srcaddr, data
  localparam int txn_w = 1 + datamode_w + ctrlmode_w + addr_w + addr_w + data_w;

  // Tag in dstaddr[31:20] that marks a write as a read response
  localparam logic [11:0] read_tag_addr = 12'h810;

  // ############################################################
  // Queue sizing
  // ############################################################

  localparam int queue_depth   = 16;
  localparam int queue_ptr_w   = $clog2(queue_depth);
  // Level spans 0..queue_depth, hence one extra bit
  localparam int queue_level_w = 5;

  // Margin above this covers words still in flight after wait rises
  localparam logic [queue_level_w-1:0] prog_full_level = 5'd12;

  // ############################################################
  // Output credits
  // ############################################################

  localparam int credit_w = 3;
  // Consumer buffer size per channel
  localparam logic [credit_w-1:0] credit_init = 3'd4;

  // Channel slots inside the flow controller
  localparam int num_ch = 3;
  localparam int ch_wr  = 0;
  localparam int ch_rq  = 1;
  localparam int ch_rr  = 2;

  // Destination address, flat or as routing tag over offset
  typedef union packed {
    logic [addr_w-1:0] flat;
    struct packed {
      logic [11:0] tag;
      logic [19:0] offset;
    } route;
  } emesh_dstaddr_u;

endpackage
